/* hw/mcu_cmd_pkg.sv */
package mcu_cmd_pkg;

   localparam int ADDR_W = 24;

   // Command opcodes, high nibble of the command byte
   typedef enum logic [3:0] {
      set_addr      = 4'd0,
      set_rom_mask  = 4'd1,
      set_sram_mask = 4'd2,
      set_mapper    = 4'd3,
      mem_read      = 4'd8,
      mem_write     = 4'd9
   } op_t;

   // Top three bits shared by mem_read and mem_write
   localparam logic [2:0] MEM_GROUP = 3'd4;

   typedef struct packed {
      op_t        opcode;
      logic [3:0] arg;
   } cmd_plain_t;

   typedef struct packed {
      logic [2:0] group;
      logic       dir;
      logic [2:0] reserved;
      logic       autoinc;
   } cmd_mem_t;

   typedef union packed {
      cmd_plain_t plain;
      cmd_mem_t   mem;
   } mcu_cmd_u;

   // One byte off the SPI link, idx 0 is the command byte
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
      logic [7:0] idx;
   } spi_byte_t;

   typedef struct packed {
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [7:0]        wdata;
   } mem_req_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] rdata;
   } mem_rsp_t;

   typedef enum logic [1:0] {
      cfg_rom_mask  = 2'd0,
      cfg_sram_mask = 2'd1,
      cfg_mapper    = 2'd2
   } cfg_sel_t;

   // byte_idx 0 addresses bits 23:16 of a mask
   typedef struct packed {
      logic       valid;
      cfg_sel_t   sel;
      logic [1:0] byte_idx;
      logic [7:0] data;
   } cfg_wr_t;

endpackage

/* hw/spi_byte_rx.sv */
`timescale 1ns/10ps

module spi_byte_rx
   import mcu_cmd_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       sck,
   input  logic       mosi,
   input  logic       cs_n,
   input  logic [7:0] tx_byte,
   input  logic       tx_load,
   output logic       miso,
   output spi_byte_t  rx,
   output logic       frame_start
);

   logic [2:0] sck_q;
   logic [2:0] cs_n_q;
   logic [1:0] mosi_q;
   logic       sck_rise;
   logic       sck_fall;
   logic       cs_fall;
   logic       cs_active;
   logic [2:0] bit_cnt;
   logic [7:0] byte_cnt;
   logic [6:0] rx_shift;
   logic [7:0] tx_shift;

   ////////////////////
   // Pin synchronizers

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sck_q  <= '0;
         cs_n_q <= '1;
         mosi_q <= '0;
      end else begin
         sck_q  <= {sck_q[1:0], sck};
         cs_n_q <= {cs_n_q[1:0], cs_n};
         mosi_q <= {mosi_q[0], mosi};
      end
   end

   // Edges seen after two stages
   assign sck_rise  = sck_q[1] & ~sck_q[2];
   assign sck_fall  = ~sck_q[1] & sck_q[2];
   assign cs_fall   = ~cs_n_q[1] & cs_n_q[2];
   assign cs_active = ~cs_n_q[1];

   ////////////////////
   // Receive side

   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_shift <= {rx_shift[5:0], mosi_q[1]};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt     <= '0;
         byte_cnt    <= '0;
         rx          <= '0;
         frame_start <= 1'b0;
      end else begin
         rx.valid    <= 1'b0;
         frame_start <= cs_fall;
         if (!cs_active) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
         end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
               rx.valid <= 1'b1;
               rx.data  <= {rx_shift, mosi_q[1]};
               rx.idx   <= byte_cnt;
               // Index sticks at 255 on long bursts
               if (byte_cnt != 8'hff) begin
                  byte_cnt <= byte_cnt + 8'd1;
               end
            end
         end
      end
   end

   ////////////////////
   // Transmit side

   // The falling edge after bit 8 is skipped so a late load survives
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_shift <= '0;
      end else if (tx_load) begin
         tx_shift <= tx_byte;
      end else if (cs_fall) begin
         tx_shift <= '0;
      end else if (sck_fall && bit_cnt != 3'd0) begin
         tx_shift <= {tx_shift[6:0], 1'b0};
      end
   end

   assign miso = tx_shift[7];

   a_tx_load_between_bytes: assert property (@(posedge clk) disable iff (!rst_n)
      tx_load |-> bit_cnt == 3'd0)
      else $error("tx_load arrived in the middle of a byte");

endmodule

/* hw/mcu_cmd_decode.sv */
`timescale 1ns/10ps

module mcu_cmd_decode
   import mcu_cmd_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  spi_byte_t  rx,
   input  logic       frame_start,
   output mem_req_t   req,
   output logic       req_valid,
   input  logic       req_ready,
   input  mem_rsp_t   rsp,
   output logic [7:0] tx_byte,
   output logic       tx_load,
   output cfg_wr_t    cfg_wr
);

   mcu_cmd_u          cmd_q;
   mcu_cmd_u          cmd_in;
   logic              cmd_seen;
   logic [ADDR_W-1:0] addr;
   logic [ADDR_W-1:0] addr_inc;
   logic              is_mem;
   logic              issue;
   mem_req_t          req_next;
   logic              rd_pending;
   logic              wr_accept;
   logic              rd_accept;

   assign cmd_in    = rx.data;
   assign addr_inc  = addr + ADDR_W'(1);
   assign is_mem    = cmd_q.mem.group == MEM_GROUP;
   assign wr_accept = req_valid & req_ready & req.write;
   assign rd_accept = req_valid & req_ready & ~req.write;

   ////////////////////
   // Request issue

   always_comb begin
      issue    = 1'b0;
      req_next = '0;
      if (rx.valid) begin
         if (rx.idx == 8'd0) begin
            // mem_read fetches its first byte right on the command
            if (cmd_in.mem.group == MEM_GROUP && !cmd_in.mem.dir) begin
               issue         = 1'b1;
               req_next.addr = addr;
            end
         end else if (cmd_seen && is_mem) begin
            issue = 1'b1;
            if (cmd_q.mem.dir) begin
               req_next.write = 1'b1;
               req_next.addr  = addr;
               req_next.wdata = rx.data;
            end else begin
               req_next.addr = cmd_q.mem.autoinc ? addr_inc : addr;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         req <= req_next;
      end
   end

   // Read data waiting for the next byte slot
   always_ff @(posedge clk) begin
      if (rsp.valid) begin
         tx_byte <= rsp.rdata;
      end
   end

   ////////////////////
   // Command state

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_q      <= '0;
         cmd_seen   <= 1'b0;
         addr       <= '0;
         req_valid  <= 1'b0;
         rd_pending <= 1'b0;
         tx_load    <= 1'b0;
         cfg_wr     <= '0;
      end else begin
         cfg_wr.valid <= 1'b0;
         tx_load      <= rsp.valid & rd_pending;

         if (issue) begin
            req_valid <= 1'b1;
         end else if (req_ready) begin
            req_valid <= 1'b0;
         end

         if (rd_accept) begin
            rd_pending <= 1'b1;
         end else if (rsp.valid) begin
            rd_pending <= 1'b0;
         end

         if (frame_start) begin
            cmd_seen <= 1'b0;
         end else if (rx.valid) begin
            if (rx.idx == 8'd0) begin
               cmd_q    <= cmd_in;
               cmd_seen <= 1'b1;
               // Mapper number rides in the command byte
               if (cmd_in.plain.opcode == set_mapper) begin
                  cfg_wr <= '{valid: 1'b1, sel: cfg_mapper, byte_idx: 2'd0,
                              data: {4'h0, cmd_in.plain.arg}};
               end
            end else if (cmd_seen) begin
               if (is_mem) begin
                  // Reads step before fetching, writes step on accept
                  if (!cmd_q.mem.dir && cmd_q.mem.autoinc) begin
                     addr <= addr_inc;
                  end
               end else if (rx.idx <= 8'd3) begin
                  case (cmd_q.plain.opcode)
                     set_addr: begin
                        case (rx.idx[1:0])
                           2'd1: addr <= {rx.data, 16'h0000};
                           2'd2: addr[15:8] <= rx.data;
                           default: addr[7:0] <= rx.data;
                        endcase
                     end
                     set_rom_mask: begin
                        cfg_wr <= '{valid: 1'b1, sel: cfg_rom_mask,
                                    byte_idx: rx.idx[1:0] - 2'd1, data: rx.data};
                     end
                     set_sram_mask: begin
                        cfg_wr <= '{valid: 1'b1, sel: cfg_sram_mask,
                                    byte_idx: rx.idx[1:0] - 2'd1, data: rx.data};
                     end
                     default: ;
                  endcase
               end
            end
         end else if (wr_accept && cmd_q.mem.autoinc) begin
            addr <= addr_inc;
         end
      end
   end

   a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid && !req_ready |=> req_valid && $stable(req))
      else $error("memory request changed under back-pressure");

   // SPI byte spacing must leave room for one full transaction
   a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      issue |-> !rd_pending && !req_valid)
      else $error("new request while another is outstanding");

endmodule

/* hw/cart_cfg_regs.sv */
`timescale 1ns/10ps

module cart_cfg_regs
   import mcu_cmd_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  cfg_wr_t           cfg_wr,
   output logic [3:0]        mapper,
   output logic [ADDR_W-1:0] rom_mask,
   output logic [ADDR_W-1:0] sram_mask
);

   // Replace one byte of a mask, index 0 is the high byte
   function automatic logic [ADDR_W-1:0] put_byte(input logic [ADDR_W-1:0] word,
                                                 input logic [1:0]        idx,
                                                 input logic [7:0]        data);
      logic [ADDR_W-1:0] res;
      res = word;
      case (idx)
         2'd0: res[23:16] = data;
         2'd1: res[15:8] = data;
         2'd2: res[7:0] = data;
         default: ;
      endcase
      return res;
   endfunction

   ////////////////////
   // Register block

   // Masks open fully out of reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mapper    <= '0;
         rom_mask  <= '1;
         sram_mask <= '1;
      end else if (cfg_wr.valid) begin
         case (cfg_wr.sel)
            cfg_rom_mask: begin
               rom_mask <= put_byte(rom_mask, cfg_wr.byte_idx, cfg_wr.data);
            end
            cfg_sram_mask: begin
               sram_mask <= put_byte(sram_mask, cfg_wr.byte_idx, cfg_wr.data);
            end
            cfg_mapper: begin
               mapper <= cfg_wr.data[3:0];
            end
            default: ;
         endcase
      end
   end

endmodule

/* hw/masked_sram_port.sv */
`timescale 1ns/10ps

module masked_sram_port
   import mcu_cmd_pkg::*;
#(
   parameter int MEM_AW = 10
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  mem_req_t          req,
   input  logic              req_valid,
   output logic              req_ready,
   output mem_rsp_t          rsp,
   input  logic [ADDR_W-1:0] rom_mask,
   input  logic [ADDR_W-1:0] sram_mask
);

   localparam int MEM_DEPTH = 1 << MEM_AW;

   logic [7:0]        mem [MEM_DEPTH];
   logic [ADDR_W-1:0] masked_addr;
   logic [MEM_AW-1:0] mem_idx;
   logic [MEM_AW-1:0] rd_idx;
   logic              accept;
   logic              rd_busy;
   logic              rsp_valid_q;
   logic [7:0]        rdata_q;

   ////////////////////
   // Address mapping

   // Bit 23 picks save-RAM, which lives in the upper half
   assign masked_addr = req.addr[ADDR_W-1] ? (req.addr & sram_mask)
                                           : (req.addr & rom_mask);
   assign mem_idx     = {req.addr[ADDR_W-1], masked_addr[MEM_AW-2:0]};

   assign req_ready = ~rd_busy;
   assign accept    = req_valid & req_ready;

   ////////////////////
   // Byte memory

   always_ff @(posedge clk) begin
      if (accept && req.write) begin
         mem[mem_idx] <= req.wdata;
      end
      if (accept && !req.write) begin
         rd_idx <= mem_idx;
      end
      if (rd_busy) begin
         rdata_q <= mem[rd_idx];
      end
   end

   // Read pipeline, response two cycles after accept
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_busy     <= 1'b0;
         rsp_valid_q <= 1'b0;
      end else begin
         rd_busy     <= accept & ~req.write;
         rsp_valid_q <= rd_busy;
      end
   end

   assign rsp = '{valid: rsp_valid_q, rdata: rdata_q};

   a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
      rsp.valid |-> $past(accept && !req.write, 2))
      else $error("read response without a read accepted two cycles before");

endmodule

/* hw/mcu_link_top.sv */
`timescale 1ns/10ps

module mcu_link_top
   import mcu_cmd_pkg::*;
#(
   parameter int MEM_AW = 10
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              sck,
   input  logic              mosi,
   input  logic              cs_n,
   output logic              miso,
   output logic [3:0]        mapper,
   output logic [ADDR_W-1:0] rom_mask,
   output logic [ADDR_W-1:0] sram_mask
);

   spi_byte_t  rx;
   logic       frame_start;
   logic [7:0] tx_byte;
   logic       tx_load;
   mem_req_t   req;
   logic       req_valid;
   logic       req_ready;
   mem_rsp_t   rsp;
   cfg_wr_t    cfg_wr;

   ////////////////////
   // SPI link and command path

   spi_byte_rx u_spi (
      .clk         (clk),
      .rst_n       (rst_n),
      .sck         (sck),
      .mosi        (mosi),
      .cs_n        (cs_n),
      .tx_byte     (tx_byte),
      .tx_load     (tx_load),
      .miso        (miso),
      .rx          (rx),
      .frame_start (frame_start)
   );

   mcu_cmd_decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx          (rx),
      .frame_start (frame_start),
      .req         (req),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .rsp         (rsp),
      .tx_byte     (tx_byte),
      .tx_load     (tx_load),
      .cfg_wr      (cfg_wr)
   );

   ////////////////////
   // Configuration and memory

   cart_cfg_regs u_cfg (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_wr    (cfg_wr),
      .mapper    (mapper),
      .rom_mask  (rom_mask),
      .sram_mask (sram_mask)
   );

   masked_sram_port #(
      .MEM_AW (MEM_AW)
   ) u_mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .rsp       (rsp),
      .rom_mask  (rom_mask),
      .sram_mask (sram_mask)
   );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

/* verification/tb_mcu_link.sv */
`timescale 1ns/10ps

module tb_mcu_link
   import mcu_cmd_pkg::*;
();

   localparam int MEM_AW    = 10;
   localparam int BYTE_CYC  = 144;  // 8 bits of 16 cycles plus the gap
   localparam int N_CFG     = 12;
   localparam int N_BURST   = 4;
   localparam int MAX_BURST = 16;
   localparam int N_FIXED   = 2;
   localparam int MAX_FIXED = 9;
   localparam int N_ROUNDS  = 2;
   localparam int N_ALIAS   = 16;
   localparam int N_TRUNC   = 3;

   logic        clk;
   logic        rst_n;
   logic        sck;
   logic        mosi;
   logic        cs_n;
   logic        miso;
   logic [3:0]  mapper;
   logic [23:0] rom_mask;
   logic [23:0] sram_mask;

   logic [31:0] rng_state = 32'hf2eb_a3e3;
   logic [7:0]  frame_tx[$];
   logic [7:0]  frame_rx[$];
   logic [23:0] alias_addrs [N_ALIAS];

   // Reference model state
   logic [7:0]  m_mem [int];
   logic [23:0] m_addr;
   logic [23:0] m_rom_mask;
   logic [23:0] m_sram_mask;
   logic [3:0]  m_mapper;

   tb_clk_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mcu_link_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .sck       (sck),
      .mosi      (mosi),
      .cs_n      (cs_n),
      .miso      (miso),
      .mapper    (mapper),
      .rom_mask  (rom_mask),
      .sram_mask (sram_mask)
   );

   ////////////////////
   // Helpers

   function automatic logic [31:0] rand_word();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic logic [23:0] rand_addr();
      logic [31:0] r;
      r = rand_word();
      return r[23:0];
   endfunction

   // Region picks the mask, top index bit follows bit 23
   function automatic int mem_index(input logic [23:0] a);
      logic [23:0]       masked;
      logic [MEM_AW-1:0] idx;
      masked = a & (a[23] ? m_sram_mask : m_rom_mask);
      idx = masked[MEM_AW-1:0];
      idx[MEM_AW-1] = a[23];
      return int'(idx);
   endfunction

   function automatic int frame_cycles(input int nbytes);
      return 16 + nbytes * BYTE_CYC;
   endfunction

   // Longest possible run, every test at its maximum length
   function automatic int run_cycles();
      int t;
      t = 16 + N_CFG * frame_cycles(5) + frame_cycles(2) + 4 * frame_cycles(4);
      t += N_BURST * (2 * frame_cycles(4) + 2 * frame_cycles(MAX_BURST + 1));
      t += N_FIXED * (frame_cycles(4) + 2 * frame_cycles(MAX_FIXED + 1));
      t += N_ROUNDS * (2 * frame_cycles(4) + 4 * N_ALIAS * (frame_cycles(4) + frame_cycles(2)));
      t += N_TRUNC * (2 * frame_cycles(4) + 4 * frame_cycles(2));
      return t;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [23:0] got,
                              input logic [23:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("*** FAILED ***");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_config();
      check_value("mapper", 24'(mapper), 24'(m_mapper));
      check_value("rom_mask", rom_mask, m_rom_mask);
      check_value("sram_mask", sram_mask, m_sram_mask);
   endtask

   ////////////////////
   // SPI master

   // Mode 0, MSB first, miso taken as sck rises
   task automatic shift_byte(input logic [7:0] tx_b, output logic [7:0] rx_b);
      for (int i = 7; i >= 0; i--) begin
         mosi = tx_b[i];
         wait_cycles(8);
         rx_b[i] = miso;
         sck = 1'b1;
         wait_cycles(8);
         sck = 1'b0;
      end
      mosi = 1'b0;
      wait_cycles(16);
   endtask

   task automatic send_frame();
      logic [7:0] got;
      frame_rx.delete();
      cs_n = 1'b0;
      wait_cycles(8);
      foreach (frame_tx[i]) begin
         shift_byte(frame_tx[i], got);
         frame_rx.push_back(got);
      end
      cs_n = 1'b1;
      wait_cycles(8);
      frame_tx.delete();
   endtask

   ////////////////////
   // Command frames

   task automatic update_model(input op_t op, input int i, input logic [7:0] b);
      case (op)
         set_addr: begin
            if (i == 0) begin
               m_addr = {b, 16'h0000};
            end else begin
               m_addr[23 - 8 * i -: 8] = b;
            end
         end
         set_rom_mask: m_rom_mask[23 - 8 * i -: 8] = b;
         set_sram_mask: m_sram_mask[23 - 8 * i -: 8] = b;
         default: ;
      endcase
   endtask

   // Bytes past the third carry random filler
   task automatic cfg_frame(input op_t op, input logic [3:0] arg,
                            input logic [23:0] value, input int nparam);
      logic [7:0]  b;
      logic [31:0] r;
      frame_tx.push_back({op, arg});
      for (int i = 0; i < nparam; i++) begin
         if (i < 3) begin
            b = value[23 - 8 * i -: 8];
            update_model(op, i, b);
         end else begin
            r = rand_word();
            b = r[7:0];
         end
         frame_tx.push_back(b);
      end
      if (op == set_mapper) begin
         m_mapper = arg;
      end
      send_frame();
   endtask

   task automatic open_masks();
      cfg_frame(set_rom_mask, 4'h0, 24'hff_ffff, 3);
      cfg_frame(set_sram_mask, 4'h0, 24'hff_ffff, 3);
   endtask

   task automatic write_burst(input logic autoinc, input int len);
      logic [31:0] r;
      frame_tx.push_back({mem_write, 3'b000, autoinc});
      for (int i = 0; i < len; i++) begin
         r = rand_word();
         frame_tx.push_back(r[7:0]);
         m_mem[mem_index(m_addr)] = r[7:0];
         if (autoinc) begin
            m_addr = m_addr + 24'd1;
         end
      end
      send_frame();
   endtask

   // Slot k returns the byte fetched after slot k-1
   task automatic read_burst(input logic autoinc, input int len);
      logic [31:0] r;
      int          k;
      frame_tx.push_back({mem_read, 3'b000, autoinc});
      for (int i = 0; i < len; i++) begin
         r = rand_word();
         frame_tx.push_back(r[7:0]);
      end
      send_frame();
      for (int i = 1; i <= len; i++) begin
         k = mem_index(m_addr);
         // Never written, nothing to compare
         if (m_mem.exists(k)) begin
            check_value("miso", 24'(frame_rx[i]), 24'(m_mem[k]));
         end
         if (autoinc) begin
            m_addr = m_addr + 24'd1;
         end
      end
   endtask

   task automatic read_at(input logic [23:0] a);
      cfg_frame(set_addr, 4'h0, a, 3);
      read_burst(1'b0, 1);
   endtask

   ////////////////////
   // Test sequence

   initial begin
      logic [31:0] r;
      logic [23:0] a;
      int          len;
      sck         = 1'b0;
      mosi        = 1'b0;
      cs_n        = 1'b1;
      m_addr      = '0;
      m_mapper    = '0;
      m_rom_mask  = '1;
      m_sram_mask = '1;
      @(posedge rst_n);
      wait_cycles(2);

      check_config();

      for (int n = 0; n < N_CFG; n++) begin
         r = rand_word();
         case (r[1:0])
            2'd0: cfg_frame(set_mapper, r[7:4], 24'h0, 0);
            2'd1: cfg_frame(set_rom_mask, 4'h0, rand_addr(), r[2] ? 4 : 3);
            default: cfg_frame(set_sram_mask, 4'h0, rand_addr(), r[2] ? 4 : 3);
         endcase
         check_config();
      end
      // Cut after the high byte
      cfg_frame(set_sram_mask, 4'h0, rand_addr(), 1);
      check_config();

      open_masks();
      for (int n = 0; n < N_BURST; n++) begin
         a = rand_addr();
         r = rand_word();
         len = 1 + int'(r[3:0]);
         cfg_frame(set_addr, 4'h0, a, 3);
         write_burst(1'b1, len);
         cfg_frame(set_addr, 4'h0, a, 3);
         read_burst(1'b1, len);
      end

      for (int n = 0; n < N_FIXED; n++) begin
         r = rand_word();
         len = 2 + int'(r[2:0]);
         cfg_frame(set_addr, 4'h0, rand_addr(), 3);
         write_burst(1'b0, len);
         read_burst(1'b0, len);
      end

      for (int n = 0; n < N_ROUNDS; n++) begin
         cfg_frame(set_rom_mask, 4'h0, rand_addr(), 3);
         cfg_frame(set_sram_mask, 4'h0, rand_addr(), 3);
         for (int i = 0; i < N_ALIAS; i++) begin
            alias_addrs[i] = rand_addr();
            cfg_frame(set_addr, 4'h0, alias_addrs[i], 3);
            write_burst(1'b0, 1);
         end
         for (int i = 0; i < N_ALIAS; i++) begin
            a = alias_addrs[i];
            read_at(a);
            // Only bits removed by the region mask are flipped
            read_at(a ^ (rand_addr() & ~(a[23] ? m_sram_mask : m_rom_mask) & 24'h7f_ffff));
            read_at(a ^ 24'h80_0000);
         end
      end

      open_masks();
      for (int n = 0; n < N_TRUNC; n++) begin
         a = rand_addr() | 24'h00_0001;
         cfg_frame(set_addr, 4'h0, {a[23:16], 16'h0000}, 3);
         write_burst(1'b0, 1);
         cfg_frame(set_addr, 4'h0, a, 3);
         write_burst(1'b0, 1);
         cfg_frame(set_addr, 4'h0, a, 1);
         read_burst(1'b0, 1);
      end

      $display("*** PASSED ***");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (run_cycles() * 3 / 2) @(posedge clk);
      $display("Timeout: the tests did not finish within the expected run time");
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

endmodule

/* filelist.f */
hw/mcu_cmd_pkg.sv
hw/spi_byte_rx.sv
hw/mcu_cmd_decode.sv
hw/cart_cfg_regs.sv
hw/masked_sram_port.sv
hw/mcu_link_top.sv
verification/tb_clk_gen.sv
verification/tb_mcu_link.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 --timescale 1ns/10ps
TOP       = tb_mcu_link
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
